//--- rtl/lut_ctrl_consts.svh
/*
  widths, clamp limits and field positions of the lut index control stage
  sample width assumes 8-bit elements summed over a 9-element window
  index fields are 10 bits, so clamp limits must stay below 1024
*/
`ifndef LUT_CTRL_CONSTS_SVH
`define LUT_CTRL_CONSTS_SVH

// sample and offset-subtracted value
`define LUT_DATA_W        21
`define LUT_WIDE_W        22

// table entry fields
`define LUT_FRAC_W        16
`define LUT_INDEX_W       10
`define LUT_START_W       38

// clamp limits, X is the exponent/linear table
`define LUT_LE_MAX_INDEX  64
`define LUT_LO_MAX_INDEX  256

// config field widths, shift code sign sits at bit 5
`define LUT_SHIFT_W       8
`define LUT_IDX_OFS_W     8
`define LUT_SHIFT_SIGN    5

`endif

//--- rtl/lut_ctrl_pkg.sv
/*
  shared types of the lut index control stage
  entry layout matches the dp2lut bus: oflow, uflow, frac, then index
  cfg fields are quasi-static and must not change with samples in flight
*/
`default_nettype none
`include "lut_ctrl_consts.svh"

package lut_pkg;

  // plain vectors
  typedef logic [`LUT_DATA_W-1:0]           lut_data_t;
  typedef logic [`LUT_WIDE_W-1:0]           lut_wide_t;
  typedef logic [`LUT_FRAC_W-1:0]           lut_frac_t;
  typedef logic [`LUT_INDEX_W-1:0]          lut_index_t;
  typedef logic [`LUT_START_W-1:0]          lut_start_t;
  typedef logic [`LUT_SHIFT_W-1:0]          lut_shift_t;
  typedef logic signed [`LUT_IDX_OFS_W-1:0] lut_idx_ofs_t;

  // value after window subtract, also reused for exponent/index
  typedef struct packed {
    logic      uflow;
    lut_wide_t value;
  } lut_win_t;

  // 18-bit info word
  typedef struct packed {
    logic      oflow;
    logic      uflow;
    lut_frac_t frac;
  } lut_info_t;

  // 28-bit table entry
  typedef struct packed {
    lut_info_t  info;
    lut_index_t index;
  } lut_entry_t;

  typedef struct packed {
    logic         le_exp;
    lut_start_t   le_start;
    lut_idx_ofs_t le_index_offset;
    lut_shift_t   le_index_select;
    lut_start_t   lo_start;
    lut_shift_t   lo_index_select;
    logic         sqsum_bypass;
  } lut_cfg_t;

endpackage

`default_nettype wire

//--- rtl/lut_window_offset.sv
/*
  input fork plus X and Y window start subtraction, one register stage
  only the low 22 bits of each start register are used, as a signed value
  both paths accept together so X and Y never drift apart
*/
`timescale 1ns/10ps
`default_nettype none
`include "lut_ctrl_consts.svh"

module lut_window_offset (
  input  logic                nvdla_core_clk,
  input  logic                nvdla_core_rstn,
  input  logic                in_pvld,
  output logic                in_prdy,
  input  lut_pkg::lut_data_t  in_pd,
  input  lut_pkg::lut_start_t le_start,
  input  lut_pkg::lut_start_t lo_start,
  input  logic                sqsum_bypass,
  output logic                x_pvld,
  input  logic                x_prdy,
  output lut_pkg::lut_win_t   x_pd,
  output logic                y_pvld,
  input  logic                y_prdy,
  output lut_pkg::lut_win_t   y_pd
);
  import lut_pkg::*;

  lut_wide_t datin_ext;
  logic      x_acc;
  logic      y_acc;
  logic      load;

  // at or below start gives uflow and a zero value
  function automatic lut_win_t win_sub(lut_wide_t din, lut_start_t start);
    lut_wide_t start_lo;
    lut_win_t  res;
    start_lo = start[`LUT_WIDE_W-1:0];
    if ($signed(din) <= $signed(start_lo)) begin
      res.uflow = 1'b1;
      res.value = '0;
    end else begin
      res.uflow = 1'b0;
      res.value = din - start_lo;
    end
    return res;
  endfunction

  // bypass mode feeds a signed sample
  assign datin_ext = sqsum_bypass ? {in_pd[`LUT_DATA_W-1], in_pd} : {1'b0, in_pd};

  ////////////////////////////////////////
  // fork interlock
  assign x_acc   = ~x_pvld | x_prdy;
  assign y_acc   = ~y_pvld | y_prdy;
  assign in_prdy = x_acc & y_acc;
  assign load    = in_pvld & in_prdy;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      x_pvld <= 1'b0;
      y_pvld <= 1'b0;
    end else begin
      if (load) begin
        x_pvld <= 1'b1;
      end else if (x_prdy) begin
        x_pvld <= 1'b0;
      end
      if (load) begin
        y_pvld <= 1'b1;
      end else if (y_prdy) begin
        y_pvld <= 1'b0;
      end
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (load) begin
      x_pd <= win_sub(datin_ext, le_start);
      y_pd <= win_sub(datin_ext, lo_start);
    end
  end

endmodule

`default_nettype wire

//--- rtl/lut_exp_index.sv
/*
  X path log2 and index offset, two register stages
  in linear mode both stages pass the value through
  exponent of the leading one is at most 21, offset is 8-bit signed
*/
`timescale 1ns/10ps
`default_nettype none
`include "lut_ctrl_consts.svh"

module lut_exp_index (
  input  logic                  nvdla_core_clk,
  input  logic                  nvdla_core_rstn,
  input  logic                  in_pvld,
  output logic                  in_prdy,
  input  lut_pkg::lut_win_t     in_pd,
  input  logic                  le_exp,
  input  lut_pkg::lut_idx_ofs_t le_index_offset,
  output logic                  out_pvld,
  input  logic                  out_prdy,
  output lut_pkg::lut_win_t     out_pd,
  output lut_pkg::lut_frac_t    out_frac
);
  import lut_pkg::*;

  localparam int pos_w = $clog2(`LUT_WIDE_W);

  logic             log_pvld;
  logic             log_prdy;
  lut_win_t         log_pd;
  lut_frac_t        log_frac;
  logic [pos_w-1:0] lead_pos;
  lut_wide_t        lead_norm;
  lut_wide_t        ofs_ext;
  logic             ofs_uflow;
  logic             load_log;
  logic             load_out;

  ////////////////////////////////////////
  // stage a, leading one search
  always_comb begin
    lead_pos = '0;
    // highest set bit wins, values 0 and 1 give 0
    for (int i = 1; i < `LUT_WIDE_W; i++) begin
      if (in_pd.value[i]) begin
        lead_pos = pos_w'(i);
      end
    end
    // leading one moved to the msb, bits below it form the fraction
    lead_norm = in_pd.value << (`LUT_WIDE_W - 1 - lead_pos);
  end

  assign log_prdy = ~out_pvld | out_prdy;
  assign in_prdy  = ~log_pvld | log_prdy;
  assign load_log = in_pvld & in_prdy;
  assign load_out = log_pvld & log_prdy;

  always_ff @(posedge nvdla_core_clk) begin
    if (load_log) begin
      log_pd.uflow <= in_pd.uflow;
      if (le_exp && !in_pd.uflow) begin
        log_pd.value <= lut_wide_t'(lead_pos);
        log_frac     <= lead_norm[`LUT_WIDE_W-2 -: `LUT_FRAC_W];
      end else begin
        // uflow already carries a zero value
        log_pd.value <= in_pd.value;
        log_frac     <= '0;
      end
    end
  end

  ////////////////////////////////////////
  // stage b, signed index offset
  assign ofs_ext = {{(`LUT_WIDE_W-`LUT_IDX_OFS_W){le_index_offset[`LUT_IDX_OFS_W-1]}},
                    le_index_offset};
  // positive offset above the exponent underflows the table
  assign ofs_uflow = le_exp & ~le_index_offset[`LUT_IDX_OFS_W-1] & (log_pd.value < ofs_ext);

  always_ff @(posedge nvdla_core_clk) begin
    if (load_out) begin
      out_frac     <= log_frac;
      out_pd.uflow <= log_pd.uflow | ofs_uflow;
      if (log_pd.uflow || ofs_uflow) begin
        out_pd.value <= '0;
      end else if (le_exp) begin
        out_pd.value <= log_pd.value - ofs_ext;
      end else begin
        out_pd.value <= log_pd.value;
      end
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      log_pvld <= 1'b0;
      out_pvld <= 1'b0;
    end else begin
      if (load_log) begin
        log_pvld <= 1'b1;
      end else if (log_prdy) begin
        log_pvld <= 1'b0;
      end
      if (load_out) begin
        out_pvld <= 1'b1;
      end else if (out_prdy) begin
        out_pvld <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/lut_index_scale.sv
/*
  shift and clamp of a table index, one register stage
  shift code is the low 6 bits of index_select, signed, negative shifts left
  frac_pass forces a zero shift and takes in_frac as the entry fraction
  max_index must fit the 10-bit index field
*/
`timescale 1ns/10ps
`default_nettype none
`include "lut_ctrl_consts.svh"

module lut_index_scale #(
  parameter int max_index = 64
) (
  input  logic                nvdla_core_clk,
  input  logic                nvdla_core_rstn,
  input  logic                in_pvld,
  output logic                in_prdy,
  input  lut_pkg::lut_win_t   in_pd,
  input  lut_pkg::lut_frac_t  in_frac,
  input  logic                frac_pass,
  input  lut_pkg::lut_shift_t index_select,
  output logic                out_pvld,
  input  logic                out_prdy,
  output lut_pkg::lut_entry_t out_pd
);
  import lut_pkg::*;

  // largest left shift is 32
  localparam int shl_max = 1 << `LUT_SHIFT_SIGN;
  localparam int raw_w   = `LUT_WIDE_W + shl_max;

  logic [`LUT_SHIFT_SIGN:0]            code;
  logic [`LUT_SHIFT_SIGN:0]            amt;
  logic                                shift_left;
  logic [raw_w-1:0]                    shl_val;
  logic [`LUT_WIDE_W+`LUT_FRAC_W-1:0]  shr_val;
  logic [raw_w-1:0]                    raw_index;
  lut_entry_t                          entry;
  logic                                load;

  assign code       = frac_pass ? '0 : index_select[`LUT_SHIFT_SIGN:0];
  assign shift_left = code[`LUT_SHIFT_SIGN];
  // magnitude of the signed code
  assign amt        = shift_left ? (~code + 1'b1) : code;

  assign shl_val   = raw_w'(in_pd.value) << amt;
  // right shift keeps 16 bits below the binary point
  assign shr_val   = {in_pd.value, {`LUT_FRAC_W{1'b0}}} >> amt;
  assign raw_index = shift_left ? shl_val
                                : raw_w'(shr_val[`LUT_WIDE_W+`LUT_FRAC_W-1:`LUT_FRAC_W]);

  always_comb begin
    entry.info.uflow = in_pd.uflow;
    if (in_pd.uflow) begin
      entry.index      = '0;
      entry.info.oflow = 1'b0;
    end else if (raw_index >= raw_w'(max_index)) begin
      // saturate at the last table entry
      entry.index      = lut_index_t'(max_index);
      entry.info.oflow = 1'b1;
    end else begin
      entry.index      = raw_index[`LUT_INDEX_W-1:0];
      entry.info.oflow = 1'b0;
    end
    if (frac_pass) begin
      entry.info.frac = in_frac;
    end else if (shift_left) begin
      entry.info.frac = '0;
    end else begin
      entry.info.frac = shr_val[`LUT_FRAC_W-1:0];
    end
  end

  ////////////////////////////////////////
  // output stage
  assign in_prdy = ~out_pvld | out_prdy;
  assign load    = in_pvld & in_prdy;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_pvld <= 1'b0;
    end else if (load) begin
      out_pvld <= 1'b1;
    end else if (out_prdy) begin
      out_pvld <= 1'b0;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (load) begin
      out_pd <= entry;
    end
  end

endmodule

`default_nettype wire

//--- rtl/lut_output_join.sv
/*
  Y alignment pipe and the X/Y output interlock
  Y is delayed by two registers to line up with the longer X path
  X side has no register here, its last stage sits in the scaler
*/
`timescale 1ns/10ps
`default_nettype none

module lut_output_join (
  input  logic                nvdla_core_clk,
  input  logic                nvdla_core_rstn,
  input  logic                x_pvld,
  output logic                x_prdy,
  input  lut_pkg::lut_entry_t x_pd,
  input  logic                y_pvld,
  output logic                y_prdy,
  input  lut_pkg::lut_entry_t y_pd,
  output logic                dp2lut_pvld,
  input  logic                dp2lut_prdy,
  output lut_pkg::lut_entry_t dp2lut_x,
  output lut_pkg::lut_entry_t dp2lut_y
);
  import lut_pkg::*;

  logic       y1_pvld;
  logic       y1_prdy;
  lut_entry_t y1_pd;
  logic       y2_pvld;
  logic       y2_prdy;
  lut_entry_t y2_pd;
  logic       load_y1;
  logic       load_y2;

  ////////////////////////////////////////
  // interlock, each side pops only on a joint transfer
  assign y2_prdy     = dp2lut_prdy & x_pvld;
  assign x_prdy      = dp2lut_prdy & y2_pvld;
  assign dp2lut_pvld = x_pvld & y2_pvld;
  assign dp2lut_x    = x_pd;
  assign dp2lut_y    = y2_pd;

  // y pipe
  assign y1_prdy = ~y2_pvld | y2_prdy;
  assign y_prdy  = ~y1_pvld | y1_prdy;
  assign load_y1 = y_pvld & y_prdy;
  assign load_y2 = y1_pvld & y1_prdy;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      y1_pvld <= 1'b0;
      y2_pvld <= 1'b0;
    end else begin
      if (load_y1) begin
        y1_pvld <= 1'b1;
      end else if (y1_prdy) begin
        y1_pvld <= 1'b0;
      end
      if (load_y2) begin
        y2_pvld <= 1'b1;
      end else if (y2_prdy) begin
        y2_pvld <= 1'b0;
      end
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (load_y1) begin
      y1_pd <= y_pd;
    end
    if (load_y2) begin
      y2_pd <= y1_pd;
    end
  end

endmodule

`default_nettype wire

//--- rtl/lut_ctrl_top.sv
/*
  lut index control top, sum-of-squares sample in, X and Y entries out
  4 cycle latency without back-pressure, up to 4 samples in flight
  cfg is not captured here and must hold while samples are in flight
*/
`timescale 1ns/10ps
`default_nettype none
`include "lut_ctrl_consts.svh"

module lut_ctrl_top (
  input  logic                nvdla_core_clk,
  input  logic                nvdla_core_rstn,
  input  logic                sum2itp_pvld,
  output logic                sum2itp_prdy,
  input  lut_pkg::lut_data_t  sum2itp_pd,
  input  lut_pkg::lut_cfg_t   cfg,
  output logic                dp2lut_pvld,
  input  logic                dp2lut_prdy,
  output lut_pkg::lut_entry_t dp2lut_x,
  output lut_pkg::lut_entry_t dp2lut_y
);
  import lut_pkg::*;

  // window outputs
  logic       x_win_pvld;
  logic       x_win_prdy;
  lut_win_t   x_win_pd;
  logic       y_win_pvld;
  logic       y_win_prdy;
  lut_win_t   y_win_pd;
  // X after log2 and index offset
  logic       x_idx_pvld;
  logic       x_idx_prdy;
  lut_win_t   x_idx_pd;
  lut_frac_t  x_idx_frac;
  // scaled entries
  logic       x_ent_pvld;
  logic       x_ent_prdy;
  lut_entry_t x_ent_pd;
  logic       y_ent_pvld;
  logic       y_ent_prdy;
  lut_entry_t y_ent_pd;

  lut_window_offset u_window (
    .nvdla_core_clk (nvdla_core_clk),
    .nvdla_core_rstn(nvdla_core_rstn),
    .in_pvld        (sum2itp_pvld),
    .in_prdy        (sum2itp_prdy),
    .in_pd          (sum2itp_pd),
    .le_start       (cfg.le_start),
    .lo_start       (cfg.lo_start),
    .sqsum_bypass   (cfg.sqsum_bypass),
    .x_pvld         (x_win_pvld),
    .x_prdy         (x_win_prdy),
    .x_pd           (x_win_pd),
    .y_pvld         (y_win_pvld),
    .y_prdy         (y_win_prdy),
    .y_pd           (y_win_pd)
  );

  lut_exp_index u_x_exp (
    .nvdla_core_clk (nvdla_core_clk),
    .nvdla_core_rstn(nvdla_core_rstn),
    .in_pvld        (x_win_pvld),
    .in_prdy        (x_win_prdy),
    .in_pd          (x_win_pd),
    .le_exp         (cfg.le_exp),
    .le_index_offset(cfg.le_index_offset),
    .out_pvld       (x_idx_pvld),
    .out_prdy       (x_idx_prdy),
    .out_pd         (x_idx_pd),
    .out_frac       (x_idx_frac)
  );

  // X table, log2 fraction taken in exponent mode
  lut_index_scale #(.max_index(`LUT_LE_MAX_INDEX)) u_x_scale (
    .nvdla_core_clk (nvdla_core_clk),
    .nvdla_core_rstn(nvdla_core_rstn),
    .in_pvld        (x_idx_pvld),
    .in_prdy        (x_idx_prdy),
    .in_pd          (x_idx_pd),
    .in_frac        (x_idx_frac),
    .frac_pass      (cfg.le_exp),
    .index_select   (cfg.le_index_select),
    .out_pvld       (x_ent_pvld),
    .out_prdy       (x_ent_prdy),
    .out_pd         (x_ent_pd)
  );

  // Y table is linear only
  lut_index_scale #(.max_index(`LUT_LO_MAX_INDEX)) u_y_scale (
    .nvdla_core_clk (nvdla_core_clk),
    .nvdla_core_rstn(nvdla_core_rstn),
    .in_pvld        (y_win_pvld),
    .in_prdy        (y_win_prdy),
    .in_pd          (y_win_pd),
    .in_frac        ('0),
    .frac_pass      (1'b0),
    .index_select   (cfg.lo_index_select),
    .out_pvld       (y_ent_pvld),
    .out_prdy       (y_ent_prdy),
    .out_pd         (y_ent_pd)
  );

  lut_output_join u_join (
    .nvdla_core_clk (nvdla_core_clk),
    .nvdla_core_rstn(nvdla_core_rstn),
    .x_pvld         (x_ent_pvld),
    .x_prdy         (x_ent_prdy),
    .x_pd           (x_ent_pd),
    .y_pvld         (y_ent_pvld),
    .y_prdy         (y_ent_prdy),
    .y_pd           (y_ent_pd),
    .dp2lut_pvld    (dp2lut_pvld),
    .dp2lut_prdy    (dp2lut_prdy),
    .dp2lut_x       (dp2lut_x),
    .dp2lut_y       (dp2lut_y)
  );

endmodule

`default_nettype wire

//--- verification/tb_lut_ctrl.sv
/*
  trace-driven testbench for the lut index control top
  the trace is run twice, first with dp2lut_prdy held high and a fixed
  4 cycle latency check, then under random back-pressure
  cfg only changes once every pending entry has come out
  run from the project root, the trace path is relative to it
*/
`timescale 1ns/10ps
`default_nettype none

module tb_lut_ctrl;
  import lut_pkg::*;

  localparam string trace_path = "verification/lut_ctrl_trace.txt";
  localparam int    latency    = 4;

  logic       nvdla_core_clk;
  logic       nvdla_core_rstn;
  logic       sum2itp_pvld;
  logic       sum2itp_prdy;
  lut_data_t  sum2itp_pd;
  lut_cfg_t   cfg;
  logic       dp2lut_pvld;
  logic       dp2lut_prdy;
  lut_entry_t dp2lut_x;
  lut_entry_t dp2lut_y;

  // trace contents
  lut_cfg_t   tr_cfg[$];
  lut_data_t  tr_data[$];
  lut_entry_t tr_x[$];
  lut_entry_t tr_y[$];

  // in-flight expectations, oldest first
  lut_entry_t exp_x_q[$];
  lut_entry_t exp_y_q[$];
  int         accept_q[$];

  int   cycle = 0;
  int   cycle_limit = 100;
  int   acc_cycle;
  logic rand_bp = 1'b0;

  lut_ctrl_top DUT (
    .nvdla_core_clk (nvdla_core_clk),
    .nvdla_core_rstn(nvdla_core_rstn),
    .sum2itp_pvld   (sum2itp_pvld),
    .sum2itp_prdy   (sum2itp_prdy),
    .sum2itp_pd     (sum2itp_pd),
    .cfg            (cfg),
    .dp2lut_pvld    (dp2lut_pvld),
    .dp2lut_prdy    (dp2lut_prdy),
    .dp2lut_x       (dp2lut_x),
    .dp2lut_y       (dp2lut_y)
  );

  initial begin
    nvdla_core_clk = 1'b0;
    forever #2 nvdla_core_clk = ~nvdla_core_clk;
  end

  ////////////////////////////////////////
  // failure reporting and compares
  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_entry(input string name, input lut_entry_t got, input lut_entry_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("FAILED %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("FAILED %s got %h expected %h", name, got, exp));
    end
  endtask

  ////////////////////////////////////////
  // trace loading
  task automatic read_trace();
    int          fd;
    int          n;
    string       line;
    logic        f_exp;
    logic [37:0] f_le_start;
    logic [7:0]  f_ofs;
    logic [7:0]  f_le_sel;
    logic [37:0] f_lo_start;
    logic [7:0]  f_lo_sel;
    logic        f_byp;
    logic [20:0] f_data;
    logic [27:0] f_x;
    logic [27:0] f_y;
    lut_cfg_t    c;
    fd = $fopen(trace_path, "r");
    if (fd == 0) begin
      stop_with_failure("could not open the trace file");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        // skip blank and comment lines
        if (line.len() < 2 || line.substr(0, 0) == "#") begin
          continue;
        end
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", f_exp, f_le_start, f_ofs,
                    f_le_sel, f_lo_start, f_lo_sel, f_byp, f_data, f_x, f_y);
        if (n != 10) begin
          stop_with_failure("a trace line does not hold ten fields");
        end else begin
          c.le_exp          = f_exp;
          c.le_start        = f_le_start;
          c.le_index_offset = f_ofs;
          c.le_index_select = f_le_sel;
          c.lo_start        = f_lo_start;
          c.lo_index_select = f_lo_sel;
          c.sqsum_bypass    = f_byp;
          tr_cfg.push_back(c);
          tr_data.push_back(f_data);
          tr_x.push_back(f_x);
          tr_y.push_back(f_y);
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////
  // driver
  task automatic wait_drained();
    while (exp_x_q.size() != 0) begin
      @(posedge nvdla_core_clk);
      #1;
    end
  endtask

  task automatic run_pass(input logic random_bp);
    lut_cfg_t cur;
    logic     have_cfg;
    have_cfg = 1'b0;
    rand_bp  = random_bp;
    foreach (tr_data[i]) begin
      // cfg is quasi-static, so the pipe drains before it moves
      if (!have_cfg || tr_cfg[i] !== cur) begin
        sum2itp_pvld = 1'b0;
        wait_drained();
        cfg      = tr_cfg[i];
        cur      = tr_cfg[i];
        have_cfg = 1'b1;
        @(posedge nvdla_core_clk);
        #1;
      end
      sum2itp_pvld = 1'b1;
      sum2itp_pd   = tr_data[i];
      @(negedge nvdla_core_clk);
      while (!sum2itp_prdy) begin
        @(negedge nvdla_core_clk);
      end
      // accepted on the coming edge
      exp_x_q.push_back(tr_x[i]);
      exp_y_q.push_back(tr_y[i]);
      accept_q.push_back(cycle);
      @(posedge nvdla_core_clk);
      #1;
    end
    sum2itp_pvld = 1'b0;
    wait_drained();
  endtask

  // output ready, random only in the second pass
  always @(posedge nvdla_core_clk) begin
    #1;
    dp2lut_prdy = rand_bp ? ($urandom_range(3) != 0) : 1'b1;
  end

  ////////////////////////////////////////
  // monitor, sampled mid-cycle
  always @(negedge nvdla_core_clk) begin
    if (nvdla_core_rstn && dp2lut_pvld && dp2lut_prdy) begin
      if (exp_x_q.size() == 0) begin
        stop_with_failure("an output transfer came with no sample pending");
      end else begin
        check_entry("dp2lut_x", dp2lut_x, exp_x_q.pop_front());
        check_entry("dp2lut_y", dp2lut_y, exp_y_q.pop_front());
        acc_cycle = accept_q.pop_front();
        if (!rand_bp && cycle - acc_cycle != latency) begin
          stop_with_failure($sformatf("an entry came out %0d cycles after its input, not %0d",
                                      cycle - acc_cycle, latency));
        end
      end
    end
  end

  // cycle count and timeout
  always @(posedge nvdla_core_clk) begin
    cycle <= cycle + 1;
    if (cycle >= cycle_limit) begin
      stop_with_failure("timeout, the trace did not finish within the cycle limit");
    end
  end

  initial begin
    void'($urandom(66579));
    nvdla_core_rstn = 1'b0;
    sum2itp_pvld    = 1'b0;
    sum2itp_pd      = '0;
    cfg             = '0;
    dp2lut_prdy     = 1'b0;
    read_trace();
    // two passes over the trace
    cycle_limit = 40 * tr_data.size() * 2 + 100;
    repeat (5) @(posedge nvdla_core_clk);
    #1;
    nvdla_core_rstn = 1'b1;
    @(negedge nvdla_core_clk);
    check_flag("dp2lut_pvld", dp2lut_pvld, 1'b0);
    check_flag("sum2itp_prdy", sum2itp_prdy, 1'b1);
    @(posedge nvdla_core_clk);
    #1;
    run_pass(1'b0);
    run_pass(1'b1);
    // a stray or repeated entry would still be offered after the drain
    repeat (2 * latency) @(negedge nvdla_core_clk);
    if (dp2lut_pvld === 1'b0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      check_flag("dp2lut_pvld", dp2lut_pvld, 1'b0);
    end
  end

endmodule

`default_nettype wire

//--- verification/lut_ctrl_trace.txt
# le_exp le_start le_index_offset le_index_select lo_start lo_index_select sqsum_bypass
# sample expected_x expected_y, all hex, entry = {oflow, uflow, frac[15:0], index[9:0]}
0 100 00 00 80 00 0 000050 4000000 4000000
0 100 00 00 80 00 0 000100 4000000 0000080
0 100 00 00 80 00 0 000120 0000020 00000a0
0 100 00 00 80 00 0 000200 8000040 8000100
0 100 00 00 80 00 0 00013f 000003f 00000bf
0 3ffffffff0 00 00 0 00 1 1ffff8 0000008 4000000
0 3ffffffff0 00 00 0 00 1 1ffff0 4000000 4000000
0 3ffffffff0 00 00 0 00 1 000010 0000020 0000010
0 3ffffffff0 00 00 0 00 1 000040 8000040 0000040
1 0 00 3e 0 00 0 000000 4000000 4000000
1 0 00 3e 0 00 0 000001 0000000 0000001
1 0 00 3e 0 00 0 000003 2000001 0000003
1 0 00 3e 0 00 0 0001a0 2800008 8000100
1 0 00 3e 0 00 0 1fffff 3fffc14 8000100
1 0 05 00 0 00 0 0001a0 2800003 8000100
1 0 05 00 0 00 0 000018 6000000 0000018
1 0 05 00 0 00 0 000020 0000000 0000020
1 0 fd 00 0 00 0 000003 2000004 0000003
1 0 fd 00 0 00 0 000001 0000003 0000001
0 0 00 02 0 3e 0 00007b 300001e 8000100
0 0 00 02 0 3e 0 000025 1000009 0000094
0 0 00 02 0 3e 0 000101 9000040 8000100
0 0 00 ff 0 04 0 00001f 000003e 3c00001
0 0 00 ff 0 04 0 000020 8000040 0000002

//--- list.f
+incdir+rtl
rtl/lut_ctrl_pkg.sv
rtl/lut_window_offset.sv
rtl/lut_exp_index.sv
rtl/lut_index_scale.sv
rtl/lut_output_join.sv
rtl/lut_ctrl_top.sv
verification/tb_lut_ctrl.sv

//--- Makefile
# Verilator build and run of the lut index control testbench

VERILATOR ?= verilator
TOP       ?= tb_lut_ctrl
OBJ_DIR   ?= obj_dir
FILELIST  ?= list.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard rtl/*.svh)
TRACE := verification/lut_ctrl_trace.txt
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) $(TRACE)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
